// ==== hdl/csr_pkg.sv ====
// machine-mode csr storage definitions
package csr_pkg;

	// data path width
	localparam int xlen = 32;

	// csr addresses as they appear in the instruction
	localparam logic [11:0] csr_addr_mstatus   = 12'h300;
	localparam logic [11:0] csr_addr_mtvec     = 12'h305;
	localparam logic [11:0] csr_addr_mepc      = 12'h341;
	localparam logic [11:0] csr_addr_mcause    = 12'h342;
	// read-only id registers
	localparam logic [11:0] csr_addr_mvendorid = 12'hF11;
	localparam logic [11:0] csr_addr_marchid   = 12'hF12;

	// mpp = machine mode out of reset
	localparam logic [xlen-1:0] mstatus_reset = 32'h0000_1800;

	// fixed id values
	localparam logic [xlen-1:0] mvendorid_value = 32'h7973_7978;
	localparam logic [xlen-1:0] marchid_value   = 32'd23060025;

	// mstatus bit positions
	// global machine interrupt enable
	localparam int mstatus_mie = 3;
	// previous mie, saved on trap entry
	localparam int mstatus_mpie = 7;
	// mpp spans this bit and the next
	localparam int mstatus_mpp_lo = 11;

	// direct mode only, low two bits of mtvec are the mode field
	localparam logic [xlen-1:0] mtvec_base_mask = 32'hFFFF_FFFC;

endpackage

// ==== hdl/csr_op_pkg.sv ====
// SYSTEM opcode encodings and csr operations
package csr_op_pkg;

	// what the decoder does to the addressed csr
	typedef enum logic [2:0] {
		op_none,
		op_write,
		op_set,
		op_clear
	} csr_op_t;

	// funct3 of the SYSTEM opcode
	// priv form carries ecall, ebreak, mret
	localparam logic [2:0] funct3_priv   = 3'b000;
	// register operand forms
	localparam logic [2:0] funct3_csrrw  = 3'b001;
	localparam logic [2:0] funct3_csrrs  = 3'b010;
	localparam logic [2:0] funct3_csrrc  = 3'b011;
	// immediate forms, zimm sits in the rs1 field
	localparam logic [2:0] funct3_csrrwi = 3'b101;
	localparam logic [2:0] funct3_csrrsi = 3'b110;
	localparam logic [2:0] funct3_csrrci = 3'b111;

	// funct12 of priv instructions, same bits as the csr address field
	localparam logic [11:0] funct12_ecall = 12'h000;
	localparam logic [11:0] funct12_mret  = 12'h302;

	// mcause for environment call from machine mode
	localparam logic [csr_pkg::xlen-1:0] cause_ecall_m = 32'd11;

endpackage

// ==== hdl/csr_write_if.sv ====
`timescale 1ns/1ns

// decoded requests from the decoder into the csr file
interface csr_write_if;

	// one-cycle write strobe
	logic                     wen;
	// target csr
	logic [11:0]              waddr;
	// already merged new value
	logic [csr_pkg::xlen-1:0] wdata;

	// trap strobes, never together with wen
	logic                     ecall;
	logic                     mret;
	// pc of the trapping instruction
	logic [csr_pkg::xlen-1:0] epc;

	// producer side
	modport decoder (
		output wen, waddr, wdata,
		output ecall, mret, epc
	);

	// storage side
	modport file (
		input wen, waddr, wdata,
		input ecall, mret, epc
	);

endinterface

// ==== hdl/csr_decoder.sv ====
`timescale 1ns/1ns

module csr_decoder (
	input  logic                     instr_valid,
	input  logic [2:0]               funct3,
	input  logic [11:0]              csr_addr,
	input  logic [4:0]               rs1_idx,
	input  logic [csr_pkg::xlen-1:0] rs1_data,
	input  logic [csr_pkg::xlen-1:0] pc,
	// old value of the csr at csr_addr
	input  logic [csr_pkg::xlen-1:0] rdata,
	csr_write_if.decoder             wr,
	output logic                     ecall,
	output logic                     mret
);

	csr_op_pkg::csr_op_t op;
	logic                     use_imm;
	logic [csr_pkg::xlen-1:0] operand;
	logic [csr_pkg::xlen-1:0] new_value;
	logic                     no_write;
	logic                     is_priv;

	// funct3 to operation and operand source
	always_comb begin
		op      = csr_op_pkg::op_none;
		use_imm = funct3[2];
		case (funct3)
			csr_op_pkg::funct3_csrrw,
			csr_op_pkg::funct3_csrrwi: op = csr_op_pkg::op_write;
			csr_op_pkg::funct3_csrrs,
			csr_op_pkg::funct3_csrrsi: op = csr_op_pkg::op_set;
			csr_op_pkg::funct3_csrrc,
			csr_op_pkg::funct3_csrrci: op = csr_op_pkg::op_clear;
			// priv form and the reserved 3'b100
			default: op = csr_op_pkg::op_none;
		endcase
	end

	// zimm is zero-extended
	assign operand = use_imm ? {{(csr_pkg::xlen-5){1'b0}}, rs1_idx} : rs1_data;

	// merge operand into the old value
	always_comb begin
		case (op)
			csr_op_pkg::op_write: new_value = operand;
			csr_op_pkg::op_set:   new_value = rdata | operand;
			csr_op_pkg::op_clear: new_value = rdata & ~operand;
			default:              new_value = rdata;
		endcase
	end

	// set/clear with x0 or zimm 0 is a pure read
	assign no_write = (op == csr_op_pkg::op_set || op == csr_op_pkg::op_clear)
		&& (rs1_idx == 5'd0);

	assign is_priv = instr_valid && (funct3 == csr_op_pkg::funct3_priv);

	// trap strobes, funct12 lives in the csr address bits
	assign ecall = is_priv && (csr_addr == csr_op_pkg::funct12_ecall);
	assign mret  = is_priv && (csr_addr == csr_op_pkg::funct12_mret);

	// write request toward the file
	assign wr.wen   = instr_valid && (op != csr_op_pkg::op_none) && !no_write;
	assign wr.waddr = csr_addr;
	assign wr.wdata = new_value;

	// trap request toward the file
	assign wr.ecall = ecall;
	assign wr.mret  = mret;
	assign wr.epc   = pc;

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/1ns

module csr_file (
	input  logic                     clock,
	input  logic                     rst_n,
	csr_write_if.file                wr,
	input  logic [11:0]              raddr,
	output logic [csr_pkg::xlen-1:0] rdata,
	output logic [csr_pkg::xlen-1:0] mtvec_q,
	output logic [csr_pkg::xlen-1:0] mepc_q
);

	logic [csr_pkg::xlen-1:0] mstatus_q;
	logic [csr_pkg::xlen-1:0] mcause_q;

	// per-csr write enables
	logic wen_mstatus;
	logic wen_mtvec;
	logic wen_mepc;
	logic wen_mcause;

	// combinational read, old value in the same cycle
	always_comb begin
		case (raddr)
			csr_pkg::csr_addr_mstatus:   rdata = mstatus_q;
			csr_pkg::csr_addr_mtvec:     rdata = mtvec_q;
			csr_pkg::csr_addr_mepc:      rdata = mepc_q;
			csr_pkg::csr_addr_mcause:    rdata = mcause_q;
			// id registers are constants
			csr_pkg::csr_addr_mvendorid: rdata = csr_pkg::mvendorid_value;
			csr_pkg::csr_addr_marchid:   rdata = csr_pkg::marchid_value;
			// unimplemented csrs read zero
			default:                     rdata = '0;
		endcase
	end

	// address decode of the write port
	// mvendorid, marchid and unknown addresses have no enable
	assign wen_mstatus = wr.wen && (wr.waddr == csr_pkg::csr_addr_mstatus);
	assign wen_mtvec   = wr.wen && (wr.waddr == csr_pkg::csr_addr_mtvec);
	assign wen_mepc    = wr.wen && (wr.waddr == csr_pkg::csr_addr_mepc);
	assign wen_mcause  = wr.wen && (wr.waddr == csr_pkg::csr_addr_mcause);

	// mstatus
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_q <= csr_pkg::mstatus_reset;
		end else if (wr.ecall) begin
			// trap entry, stack mie into mpie
			mstatus_q[csr_pkg::mstatus_mpie] <= mstatus_q[csr_pkg::mstatus_mie];
			mstatus_q[csr_pkg::mstatus_mie]  <= 1'b0;
			// trapped from machine mode
			mstatus_q[csr_pkg::mstatus_mpp_lo +: 2] <= 2'b11;
		end else if (wr.mret) begin
			// trap return, pop mpie back into mie
			mstatus_q[csr_pkg::mstatus_mie]  <= mstatus_q[csr_pkg::mstatus_mpie];
			mstatus_q[csr_pkg::mstatus_mpie] <= 1'b1;
			// machine is the lowest mode, so mpp stays machine
			mstatus_q[csr_pkg::mstatus_mpp_lo +: 2] <= 2'b11;
		end else if (wen_mstatus) begin
			mstatus_q <= wr.wdata;
		end
	end

	// mtvec, all bits kept
	// mode bits are masked only at redirect time
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mtvec_q <= '0;
		end else if (wen_mtvec) begin
			mtvec_q <= wr.wdata;
		end
	end

	// mepc
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mepc_q <= '0;
		end else if (wr.ecall) begin
			// save pc of the ecall itself
			mepc_q <= wr.epc;
		end else if (wen_mepc) begin
			mepc_q <= wr.wdata;
		end
	end

	// mcause
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mcause_q <= '0;
		end else if (wr.ecall) begin
			// only trap source here
			mcause_q <= csr_op_pkg::cause_ecall_m;
		end else if (wen_mcause) begin
			mcause_q <= wr.wdata;
		end
	end

endmodule

// ==== hdl/trap_redirect.sv ====
`timescale 1ns/1ns

module trap_redirect (
	input  logic                     clock,
	input  logic                     rst_n,
	// trap strobes from the decoder
	input  logic                     ecall,
	input  logic                     mret,
	// current csr state, before any same-cycle write
	input  logic [csr_pkg::xlen-1:0] mtvec_q,
	input  logic [csr_pkg::xlen-1:0] mepc_q,
	output logic                     redirect_valid,
	output logic [csr_pkg::xlen-1:0] redirect_pc
);

	// one-cycle pulse per trap
	// back-to-back traps give back-to-back pulses
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			redirect_valid <= 1'b0;
		end else begin
			redirect_valid <= ecall || mret;
		end
	end

	// target pc, only meaningful with redirect_valid
	always_ff @(posedge clock) begin
		if (ecall) begin
			// direct mode, jump to the base
			redirect_pc <= mtvec_q & csr_pkg::mtvec_base_mask;
		end else if (mret) begin
			// back to the saved pc
			redirect_pc <= mepc_q;
		end
	end

endmodule

// ==== hdl/csr_unit.sv ====
`timescale 1ns/1ns

module csr_unit (
	input  logic                     clock,
	input  logic                     rst_n,
	// fields of the SYSTEM instruction
	input  logic                     instr_valid,
	input  logic [2:0]               funct3,
	input  logic [11:0]              csr_addr,
	input  logic [4:0]               rs1_idx,
	input  logic [csr_pkg::xlen-1:0] rs1_data,
	input  logic [csr_pkg::xlen-1:0] pc,
	// old csr value for rd
	output logic [csr_pkg::xlen-1:0] rd_data,
	// next-cycle pc redirect
	output logic                     redirect_valid,
	output logic [csr_pkg::xlen-1:0] redirect_pc
);

	// decoder to file requests
	csr_write_if wr_if ();

	// trap strobes to the redirect unit
	logic                     ecall;
	logic                     mret;
	// csr state feeding the redirect
	logic [csr_pkg::xlen-1:0] mtvec_q;
	logic [csr_pkg::xlen-1:0] mepc_q;

	// producer of writes and traps
	csr_decoder i_csr_decoder (
		.instr_valid (instr_valid),
		.funct3      (funct3),
		.csr_addr    (csr_addr),
		.rs1_idx     (rs1_idx),
		.rs1_data    (rs1_data),
		.pc          (pc),
		.rdata       (rd_data),
		.wr          (wr_if.decoder),
		.ecall       (ecall),
		.mret        (mret)
	);

	// csr storage, read port on the instruction's address
	csr_file i_csr_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.wr      (wr_if.file),
		.raddr   (csr_addr),
		.rdata   (rd_data),
		.mtvec_q (mtvec_q),
		.mepc_q  (mepc_q)
	);

	// consumer of trap events
	trap_redirect i_trap_redirect (
		.clock          (clock),
		.rst_n          (rst_n),
		.ecall          (ecall),
		.mret           (mret),
		.mtvec_q        (mtvec_q),
		.mepc_q         (mepc_q),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

endmodule

// ==== test/csr_unit_sva.sv ====
`timescale 1ns/1ns

// redirect rules, bound into trap_redirect
module csr_unit_sva (
	input logic                     clock,
	input logic                     rst_n,
	input logic                     ecall,
	input logic                     mret,
	input logic                     redirect_valid,
	input logic [csr_pkg::xlen-1:0] redirect_pc
);

	// failed assertions so far
	int fail_count = 0;

	// a second pulse in a row needs its own trap in the cycle before
	property pulse_needs_trap;
		@(posedge clock) disable iff (!rst_n)
		redirect_valid && $past(redirect_valid) |-> $past(ecall || mret);
	endproperty

	// no redirect while reset is held
	property quiet_in_reset;
		@(posedge clock) !rst_n |-> !redirect_valid;
	endproperty

	// trap vector is word aligned in direct mode
	property ecall_target_aligned;
		@(posedge clock) disable iff (!rst_n)
		ecall |=> redirect_pc[1:0] == 2'b00;
	endproperty

	a_pulse_needs_trap: assert property (pulse_needs_trap)
		else begin
			$error("redirect_valid high twice without a trap in between");
			fail_count++;
		end
	a_quiet_in_reset: assert property (quiet_in_reset)
		else begin
			$error("redirect_valid high during reset");
			fail_count++;
		end
	a_ecall_target_aligned: assert property (ecall_target_aligned)
		else begin
			$error("redirect_pc after ecall has mode bits set");
			fail_count++;
		end

endmodule

// ==== test/csr_unit_tb.sv ====
`timescale 1ns/1ns

module csr_unit_tb;

	logic                     clock;
	logic                     rst_n;
	logic                     instr_valid;
	logic [2:0]               funct3;
	logic [11:0]              csr_addr;
	logic [4:0]               rs1_idx;
	logic [csr_pkg::xlen-1:0] rs1_data;
	logic [csr_pkg::xlen-1:0] pc;
	logic [csr_pkg::xlen-1:0] rd_data;
	logic                     redirect_valid;
	logic [csr_pkg::xlen-1:0] redirect_pc;

	// model of mstatus, mtvec, mepc, mcause, mvendorid, marchid
	logic [csr_pkg::xlen-1:0] model [0:5];
	// expectation for the instruction now on the inputs
	logic [csr_pkg::xlen-1:0] cur_exp_rd;
	logic                     cur_exp_rv;
	logic [csr_pkg::xlen-1:0] cur_exp_rpc;
	// redirect owed in the following cycle
	logic                     pend_rv;
	logic [csr_pkg::xlen-1:0] pend_rpc;
	logic                     checking;
	integer                   seed;
	string                    test_name;
	int                       errors;
	int                       test_errors;
	int                       checks;
	int                       tests_run;
	int                       tests_failed;

	csr_unit i_csr_unit (
		.clock          (clock),
		.rst_n          (rst_n),
		.instr_valid    (instr_valid),
		.funct3         (funct3),
		.csr_addr       (csr_addr),
		.rs1_idx        (rs1_idx),
		.rs1_data       (rs1_data),
		.pc             (pc),
		.rd_data        (rd_data),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	bind trap_redirect csr_unit_sva i_csr_unit_sva (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// slot in the model, -1 for unimplemented addresses
	function automatic int csr_slot(input logic [11:0] addr);
		case (addr)
			csr_pkg::csr_addr_mstatus:   return 0;
			csr_pkg::csr_addr_mtvec:     return 1;
			csr_pkg::csr_addr_mepc:      return 2;
			csr_pkg::csr_addr_mcause:    return 3;
			csr_pkg::csr_addr_mvendorid: return 4;
			csr_pkg::csr_addr_marchid:   return 5;
			default:                     return -1;
		endcase
	endfunction

	function automatic void reset_model();
		model[0] = csr_pkg::mstatus_reset;
		model[1] = '0;
		model[2] = '0;
		model[3] = '0;
		model[4] = csr_pkg::mvendorid_value;
		model[5] = csr_pkg::marchid_value;
	endfunction

	// reference: returns rd, updates the model, gives the redirect
	function automatic logic [csr_pkg::xlen-1:0] predict(
		input  logic [2:0]               f3,
		input  logic [11:0]              addr,
		input  logic [4:0]               idx,
		input  logic [csr_pkg::xlen-1:0] data,
		input  logic [csr_pkg::xlen-1:0] ipc,
		output logic                     rv,
		output logic [csr_pkg::xlen-1:0] rpc
	);
		int                       slot;
		logic [csr_pkg::xlen-1:0] old;
		logic [csr_pkg::xlen-1:0] src;
		logic [csr_pkg::xlen-1:0] ms;
		slot = csr_slot(addr);
		old = (slot < 0) ? '0 : model[slot];
		rv = 1'b0;
		rpc = '0;
		// immediate forms take the rs1 field as a 5-bit zimm
		src = (f3 inside {csr_op_pkg::funct3_csrrwi, csr_op_pkg::funct3_csrrsi,
			csr_op_pkg::funct3_csrrci}) ? {27'd0, idx} : data;
		ms = model[0];
		case (f3)
			csr_op_pkg::funct3_csrrw, csr_op_pkg::funct3_csrrwi: begin
				if (slot >= 0 && slot < 4) model[slot] = src;
			end
			csr_op_pkg::funct3_csrrs, csr_op_pkg::funct3_csrrsi: begin
				if (slot >= 0 && slot < 4 && idx != 0) model[slot] = old | src;
			end
			csr_op_pkg::funct3_csrrc, csr_op_pkg::funct3_csrrci: begin
				if (slot >= 0 && slot < 4 && idx != 0) model[slot] = old & ~src;
			end
			csr_op_pkg::funct3_priv: begin
				if (addr == csr_op_pkg::funct12_ecall) begin
					rv = 1'b1;
					rpc = model[1] & ~32'h3;
					model[2] = ipc;
					model[3] = csr_op_pkg::cause_ecall_m;
					ms[csr_pkg::mstatus_mpie] = ms[csr_pkg::mstatus_mie];
					ms[csr_pkg::mstatus_mie] = 1'b0;
					ms[csr_pkg::mstatus_mpp_lo +: 2] = 2'b11;
					model[0] = ms;
				end else if (addr == csr_op_pkg::funct12_mret) begin
					rv = 1'b1;
					rpc = model[2];
					ms[csr_pkg::mstatus_mie] = ms[csr_pkg::mstatus_mpie];
					ms[csr_pkg::mstatus_mpie] = 1'b1;
					ms[csr_pkg::mstatus_mpp_lo +: 2] = 2'b11;
					model[0] = ms;
				end
			end
			default: ;
		endcase
		return old;
	endfunction

	function automatic logic [csr_pkg::xlen-1:0] rand_word();
		return $random(seed);
	endfunction

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	// one instruction, valid for one cycle unless another follows
	task automatic issue(input logic [2:0] f3, input logic [11:0] addr,
		input logic [4:0] idx, input logic [csr_pkg::xlen-1:0] data);
		logic                     rv;
		logic [csr_pkg::xlen-1:0] rpc;
		logic [csr_pkg::xlen-1:0] ipc;
		ipc = rand_word() & ~32'h3;
		@(posedge clock);
		#10;
		instr_valid = 1'b1;
		funct3 = f3;
		csr_addr = addr;
		rs1_idx = idx;
		rs1_data = data;
		pc = ipc;
		cur_exp_rd = predict(f3, addr, idx, data, ipc, rv, rpc);
		cur_exp_rv = rv;
		cur_exp_rpc = rpc;
	endtask

	// csrrs with x0 is a pure read
	task automatic read_csr(input logic [11:0] addr);
		issue(csr_op_pkg::funct3_csrrs, addr, 5'd0, rand_word());
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			#10;
			instr_valid = 1'b0;
		end
	endtask

	// redirect should come exactly one cycle after the trap
	task automatic wait_redirect(input int max_cycles);
		int n;
		idle(1);
		// now one cycle past the trap
		n = 1;
		while (!redirect_valid && n < max_cycles) begin
			@(posedge clock);
			#10;
			n++;
		end
		checks++;
		if (!redirect_valid) begin
			$display("%s: redirect_valid never rose within %0d cycles", test_name, max_cycles);
			count_error();
		end else begin
			assert (n == 1) else begin
				$display("Fail %s redirect latency: expected %0d, actual %0d", test_name, 1, n);
				count_error();
			end
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		idle(2);
		tests_run++;
		if (test_errors != 0) tests_failed++;
		if (test_errors == 0) $display("%s: ok", test_name);
		else $display("%s: %0d errors", test_name, test_errors);
	endtask

	// compare rd in the same cycle and the redirect one cycle later
	always @(negedge clock) begin
		if (checking) begin
			checks++;
			assert (redirect_valid === pend_rv) else begin
				$display("Fail %s redirect_valid: expected %b, actual %b",
					test_name, pend_rv, redirect_valid);
				count_error();
			end
			if (pend_rv) begin
				checks++;
				assert (redirect_pc === pend_rpc) else begin
					$display("Fail %s redirect_pc: expected %h, actual %h",
						test_name, pend_rpc, redirect_pc);
					count_error();
				end
			end
			if (instr_valid) begin
				checks++;
				assert (rd_data === cur_exp_rd) else begin
					$display("Fail %s rd_data at %h: expected %h, actual %h",
						test_name, csr_addr, cur_exp_rd, rd_data);
					count_error();
				end
			end
			pend_rv = instr_valid && cur_exp_rv;
			pend_rpc = cur_exp_rpc;
		end
	end

	initial begin
		logic [11:0]              rw_addrs [0:3];
		logic [2:0]               forms [0:5];
		logic [11:0]              ro_addrs [0:2];
		logic [11:0]              all_addrs [0:7];
		logic [csr_pkg::xlen-1:0] w;
		logic [4:0]               idx;
		logic [2:0]               f3;
		logic [11:0]              addr;
		rw_addrs = '{csr_pkg::csr_addr_mstatus, csr_pkg::csr_addr_mtvec,
			csr_pkg::csr_addr_mepc, csr_pkg::csr_addr_mcause};
		forms = '{csr_op_pkg::funct3_csrrw, csr_op_pkg::funct3_csrrs,
			csr_op_pkg::funct3_csrrc, csr_op_pkg::funct3_csrrwi,
			csr_op_pkg::funct3_csrrsi, csr_op_pkg::funct3_csrrci};
		ro_addrs = '{csr_pkg::csr_addr_mvendorid, csr_pkg::csr_addr_marchid, 12'h7C0};
		all_addrs = '{csr_pkg::csr_addr_mstatus, csr_pkg::csr_addr_mtvec,
			csr_pkg::csr_addr_mepc, csr_pkg::csr_addr_mcause,
			csr_pkg::csr_addr_mvendorid, csr_pkg::csr_addr_marchid, 12'h7C0, 12'h340};
		seed = 32'h9c22f0c7;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		funct3 = '0;
		csr_addr = '0;
		rs1_idx = '0;
		rs1_data = '0;
		pc = '0;
		cur_exp_rd = '0;
		cur_exp_rv = 1'b0;
		cur_exp_rpc = '0;
		pend_rv = 1'b0;
		pend_rpc = '0;
		checking = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		reset_model();
		repeat (3) @(posedge clock);
		#10;
		rst_n = 1'b1;
		checking = 1'b1;

		start_test("reset_values");
		for (int i = 0; i < 6; i++) read_csr(all_addrs[i]);
		end_test();

		start_test("write_set_clear");
		foreach (rw_addrs[a]) begin
			foreach (forms[f]) begin
				w = rand_word();
				// register forms here use a nonzero rs1
				idx = (forms[f][2] || w[4:0] != 0) ? w[4:0] : 5'd1;
				issue(forms[f], rw_addrs[a], idx, rand_word());
				read_csr(rw_addrs[a]);
			end
		end
		// x0 and zimm 0 leave the csr alone
		issue(csr_op_pkg::funct3_csrrw, csr_pkg::csr_addr_mtvec, 5'd3, 32'h0F0F_5A5A);
		issue(csr_op_pkg::funct3_csrrs, csr_pkg::csr_addr_mtvec, 5'd0, 32'hFFFF_FFFF);
		issue(csr_op_pkg::funct3_csrrc, csr_pkg::csr_addr_mtvec, 5'd0, 32'hFFFF_FFFF);
		issue(csr_op_pkg::funct3_csrrsi, csr_pkg::csr_addr_mtvec, 5'd0, 32'hFFFF_FFFF);
		issue(csr_op_pkg::funct3_csrrci, csr_pkg::csr_addr_mtvec, 5'd0, 32'hFFFF_FFFF);
		read_csr(csr_pkg::csr_addr_mtvec);
		end_test();

		start_test("read_only");
		foreach (ro_addrs[a]) begin
			issue(csr_op_pkg::funct3_csrrw, ro_addrs[a], 5'd7, rand_word());
			issue(csr_op_pkg::funct3_csrrsi, ro_addrs[a], 5'd31, '0);
			read_csr(ro_addrs[a]);
		end
		end_test();

		start_test("ecall");
		issue(csr_op_pkg::funct3_csrrw, csr_pkg::csr_addr_mtvec, 5'd4, rand_word() | 32'h1);
		// mie on, so mpie should pick it up
		issue(csr_op_pkg::funct3_csrrsi, csr_pkg::csr_addr_mstatus, 5'd8, '0);
		issue(csr_op_pkg::funct3_priv, csr_op_pkg::funct12_ecall, 5'd0, '0);
		wait_redirect(8);
		read_csr(csr_pkg::csr_addr_mepc);
		read_csr(csr_pkg::csr_addr_mcause);
		read_csr(csr_pkg::csr_addr_mstatus);
		end_test();

		start_test("mret");
		issue(csr_op_pkg::funct3_csrrw, csr_pkg::csr_addr_mepc, 5'd5, rand_word() & ~32'h3);
		issue(csr_op_pkg::funct3_csrrci, csr_pkg::csr_addr_mstatus, 5'd8, '0);
		issue(csr_op_pkg::funct3_priv, csr_op_pkg::funct12_mret, 5'd0, '0);
		wait_redirect(8);
		read_csr(csr_pkg::csr_addr_mstatus);
		// mie on and mpie off, so mpie has to be set by the return
		issue(csr_op_pkg::funct3_csrrc, csr_pkg::csr_addr_mstatus, 5'd9, 32'h0000_0080);
		issue(csr_op_pkg::funct3_priv, csr_op_pkg::funct12_mret, 5'd0, '0);
		wait_redirect(8);
		read_csr(csr_pkg::csr_addr_mstatus);
		end_test();

		start_test("random_mix");
		// back-to-back traps up front
		issue(csr_op_pkg::funct3_priv, csr_op_pkg::funct12_ecall, 5'd0, '0);
		issue(csr_op_pkg::funct3_priv, csr_op_pkg::funct12_ecall, 5'd0, '0);
		issue(csr_op_pkg::funct3_priv, csr_op_pkg::funct12_mret, 5'd0, '0);
		issue(csr_op_pkg::funct3_priv, csr_op_pkg::funct12_mret, 5'd0, '0);
		for (int i = 0; i < 200; i++) begin
			w = rand_word();
			// extra weight on traps
			f3 = (w[31:29] == 3'd0) ? csr_op_pkg::funct3_priv : w[2:0];
			if (f3 == csr_op_pkg::funct3_priv) begin
				addr = w[8] ? csr_op_pkg::funct12_mret : csr_op_pkg::funct12_ecall;
				if (w[11:9] == 3'd7) addr = 12'h105;
			end else begin
				addr = all_addrs[w[10:8]];
			end
			issue(f3, addr, w[16:12], rand_word());
			if (w[27:25] == 3'd0) idle(1);
		end
		end_test();

		// bound assertion failures count against the run
		errors += i_csr_unit.i_trap_redirect.i_csr_unit_sva.fail_count;
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
hdl/csr_pkg.sv
hdl/csr_op_pkg.sv
hdl/csr_write_if.sv
hdl/csr_decoder.sv
hdl/csr_file.sv
hdl/trap_redirect.sv
hdl/csr_unit.sv
test/csr_unit_sva.sv
test/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  # packages first, then the interface and the modules
  - hdl/csr_pkg.sv
  - hdl/csr_op_pkg.sv
  - hdl/csr_write_if.sv
  - hdl/csr_decoder.sv
  - hdl/csr_file.sv
  - hdl/trap_redirect.sv
  - hdl/csr_unit.sv
  - target: test
    files:
      - test/csr_unit_sva.sv
      - test/csr_unit_tb.sv
